// ==== hw/nn_pkg.sv ====
`include "nn_settings.svh"

package nn_pkg;

	////////////////////////////////////////
	// Cell and vector types
	////////////////////////////////////////

	// Row counter, wide enough to hold NEURON_NUM
	localparam int ROW_IDX_WIDTH = $clog2(`NEURON_NUM + 1);

	// Configuration register map
	localparam logic CFG_ADDR_LR_SHIFT = 1'b0;
	localparam logic CFG_ADDR_SAT_EN   = 1'b1;

	typedef logic        [`ACTIVATION_WIDTH-1:0]  act_cell_t;
	typedef logic signed [`DELTA_CELL_WIDTH-1:0]  delta_cell_t;
	typedef logic signed [`WEIGHT_CELL_WIDTH-1:0] weight_cell_t;
	typedef logic        [ROW_IDX_WIDTH-1:0]      row_idx_t;

	// Vectors indexed by neuron, matrix indexed [j][i]
	typedef act_cell_t    [`NEURON_NUM-1:0] act_vec_t;
	typedef delta_cell_t  [`NEURON_NUM-1:0] delta_vec_t;
	typedef weight_cell_t [`NEURON_NUM-1:0] weight_row_t;
	typedef weight_row_t  [`NEURON_NUM-1:0] weight_mat_t;

	////////////////////////////////////////
	// Transfer types
	////////////////////////////////////////

	// Full job from upstream
	typedef struct packed {
		act_vec_t    a;
		delta_vec_t  delta;
		weight_mat_t w;
	} upd_job_t;

	// Finished job
	typedef struct packed {
		weight_mat_t w;
		logic        error;
	} upd_result_t;

	// One row into the cell pipeline
	typedef struct packed {
		row_idx_t    row;
		delta_cell_t delta_j;
		act_vec_t    a;
		weight_row_t w_row;
	} row_req_t;

	// One updated row out of the cell pipeline
	typedef struct packed {
		row_idx_t    row;
		weight_row_t w_row;
		logic        ovf;
	} row_rsp_t;

	// Config write port
	typedef struct packed {
		logic       addr;
		logic [7:0] data;
	} cfg_wr_t;

	// Settings seen by the datapath
	typedef struct packed {
		logic [`LR_SHIFT_WIDTH-1:0] lr_shift;
		logic                       sat_en;
	} upd_cfg_t;

endpackage

// ==== hw/nn_settings.svh ====
`ifndef NN_SETTINGS_SVH
`define NN_SETTINGS_SVH

////////////////////////////////////////
// Layer geometry
////////////////////////////////////////

// Neurons per layer, also rows and columns of the weight matrix
`define NEURON_NUM 5

////////////////////////////////////////
// Cell widths
////////////////////////////////////////

// Unsigned activation from the forward pass
`define ACTIVATION_WIDTH 9
// Signed error term per neuron
`define DELTA_CELL_WIDTH 12
// Signed weight
`define WEIGHT_CELL_WIDTH 16
// Fixed-point fraction bits dropped from each product
`define FRACTION_WIDTH 0
// Learning-rate shift field
`define LR_SHIFT_WIDTH 4

`endif

// ==== hw/update_cfg_regs.sv ====
`timescale 1ns/1ps
`include "nn_settings.svh"

module update_cfg_regs (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             cfg_we,
	input  nn_pkg::cfg_wr_t  cfg,
	output nn_pkg::upd_cfg_t upd_cfg
);
	import nn_pkg::*;

	// Largest shift the lr_shift field can hold
	localparam int LR_SHIFT_MAX = (1 << `LR_SHIFT_WIDTH) - 1;

	////////////////////////////////////////
	// Register file
	////////////////////////////////////////

	// Two single-field registers, selected by addr
	// Defaults give plain gradient step with saturation
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			upd_cfg.lr_shift <= '0;
			upd_cfg.sat_en   <= 1'b1;
		end else if (cfg_we) begin
			case (cfg.addr)
				CFG_ADDR_LR_SHIFT: begin
					// Low data bits only
					upd_cfg.lr_shift <= cfg.data[`LR_SHIFT_WIDTH-1:0];
				end
				CFG_ADDR_SAT_EN: begin
					upd_cfg.sat_en <= cfg.data[0];
				end
			endcase
		end
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	// Software must not program a shift the field would truncate
	lr_shift_range_a: assert property (@(posedge clk) disable iff (!arst_n)
		(cfg_we && cfg.addr == CFG_ADDR_LR_SHIFT) |-> (int'(cfg.data) <= LR_SHIFT_MAX))
		else $error("lr_shift write out of range: %0h", cfg.data);

endmodule

// ==== hw/weight_row_update.sv ====
`timescale 1ns/1ps
`include "nn_settings.svh"

module weight_row_update (
	input  logic             clk,
	input  logic             arst_n,
	input  nn_pkg::upd_cfg_t upd_cfg,
	input  logic             row_valid,
	input  nn_pkg::row_req_t row_req,
	output logic             rsp_valid,
	output nn_pkg::row_rsp_t row_rsp
);
	import nn_pkg::*;

	// Delta times zero-extended activation
	localparam int PROD_WIDTH = `DELTA_CELL_WIDTH + `ACTIVATION_WIDTH + 1;
	// Wider operand plus one guard bit for the subtract
	localparam int DIFF_WIDTH = ((PROD_WIDTH > `WEIGHT_CELL_WIDTH) ?
		PROD_WIDTH : `WEIGHT_CELL_WIDTH) + 1;
	// Bits that all equal the sign when the result fits a weight
	localparam int TOP_WIDTH = DIFF_WIDTH - `WEIGHT_CELL_WIDTH + 1;

	// Weight range limits
	localparam weight_cell_t W_MAX = {1'b0, {(`WEIGHT_CELL_WIDTH - 1){1'b1}}};
	localparam weight_cell_t W_MIN = {1'b1, {(`WEIGHT_CELL_WIDTH - 1){1'b0}}};

	// Stage 1
	logic signed [PROD_WIDTH-1:0] prod [`NEURON_NUM];
	logic signed [PROD_WIDTH-1:0] s1_prod [`NEURON_NUM];
	logic                         s1_valid;
	row_idx_t                     s1_row;
	weight_row_t                  s1_w_row;
	logic                         s1_sat_en;

	// Stage 2
	logic signed [DIFF_WIDTH-1:0] diff [`NEURON_NUM];
	logic [`NEURON_NUM-1:0]       cell_ovf;
	weight_row_t                  new_w_row;

	////////////////////////////////////////
	// Stage 1, scaled products
	////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < `NEURON_NUM; i++) begin
			// Activation is unsigned, so pad a zero sign bit
			prod[i] = $signed(row_req.delta_j) * $signed({1'b0, row_req.a[i]});
			// Fraction scaling and learning rate in one arithmetic shift
			prod[i] = prod[i] >>> (`FRACTION_WIDTH + upd_cfg.lr_shift);
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= row_valid;
		end
	end

	// Row data rides along with its products
	always_ff @(posedge clk) begin
		if (row_valid) begin
			s1_prod   <= prod;
			s1_row    <= row_req.row;
			s1_w_row  <= row_req.w_row;
			s1_sat_en <= upd_cfg.sat_en;
		end
	end

	////////////////////////////////////////
	// Stage 2, subtract and limit
	////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < `NEURON_NUM; i++) begin
			// Full precision, no overflow possible here
			diff[i] = $signed(s1_w_row[i]) - s1_prod[i];
			// Out of range unless top bits are all zeros or all ones
			cell_ovf[i] = (diff[i][DIFF_WIDTH-1 -: TOP_WIDTH] != '0) &&
				(diff[i][DIFF_WIDTH-1 -: TOP_WIDTH] != '1);
			if (cell_ovf[i] && s1_sat_en) begin
				// Clamp toward the side the true result lies on
				new_w_row[i] = diff[i][DIFF_WIDTH-1] ? W_MIN : W_MAX;
			end else begin
				// Wrap, or plain in-range result
				new_w_row[i] = diff[i][`WEIGHT_CELL_WIDTH-1:0];
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (s1_valid) begin
			row_rsp.row   <= s1_row;
			row_rsp.w_row <= new_w_row;
			// Any cell out of range flags the whole row
			row_rsp.ovf   <= |cell_ovf;
		end
	end

	// Fixed two-cycle latency, the sequencer relies on it
	latency_a: assert property (@(posedge clk) disable iff (!arst_n)
		rsp_valid == $past(row_valid, 2))
		else $error("Row pipeline latency broken");

endmodule

// ==== hw/weight_update_top.sv ====
`timescale 1ns/1ps

module weight_update_top (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                cfg_we,
	input  nn_pkg::cfg_wr_t     cfg,
	input  logic                in_valid,
	output logic                in_ready,
	input  nn_pkg::upd_job_t    in_job,
	output logic                out_valid,
	input  logic                out_ready,
	output nn_pkg::upd_result_t out_result
);
	import nn_pkg::*;

	// Config to datapath
	upd_cfg_t upd_cfg;

	// Sequencer to row pipeline and back
	logic     row_valid;
	row_req_t row_req;
	logic     rsp_valid;
	row_rsp_t row_rsp;

	update_cfg_regs cfg_regs_inst (
		.clk     (clk    ),
		.arst_n  (arst_n ),
		.cfg_we  (cfg_we ),
		.cfg     (cfg    ),
		.upd_cfg (upd_cfg)
	);

	weight_updater updater_inst (
		.clk        (clk       ),
		.arst_n     (arst_n    ),
		.in_valid   (in_valid  ),
		.in_ready   (in_ready  ),
		.in_job     (in_job    ),
		.out_valid  (out_valid ),
		.out_ready  (out_ready ),
		.out_result (out_result),
		.row_valid  (row_valid ),
		.row_req    (row_req   ),
		.rsp_valid  (rsp_valid ),
		.row_rsp    (row_rsp   )
	);

	weight_row_update row_update_inst (
		.clk       (clk      ),
		.arst_n    (arst_n   ),
		.upd_cfg   (upd_cfg  ),
		.row_valid (row_valid),
		.row_req   (row_req  ),
		.rsp_valid (rsp_valid),
		.row_rsp   (row_rsp  )
	);

endmodule

// ==== hw/weight_updater.sv ====
`timescale 1ns/1ps
`include "nn_settings.svh"

module weight_updater (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                in_valid,
	output logic                in_ready,
	input  nn_pkg::upd_job_t    in_job,
	output logic                out_valid,
	input  logic                out_ready,
	output nn_pkg::upd_result_t out_result,
	output logic                row_valid,
	output nn_pkg::row_req_t    row_req,
	input  logic                rsp_valid,
	input  nn_pkg::row_rsp_t    row_rsp
);
	import nn_pkg::*;

	localparam row_idx_t LAST_ROW = row_idx_t'(`NEURON_NUM - 1);

	// Job copy and issue position
	upd_job_t    job_q;
	row_idx_t    issue_row;

	// Result being assembled
	weight_mat_t res_w;
	logic        res_err;

	// Handshake events
	logic        accept;
	logic        send;
	logic        last_rsp;

	assign accept   = in_valid && in_ready;
	assign send     = out_valid && out_ready;
	assign last_rsp = rsp_valid && (row_rsp.row == LAST_ROW);

	////////////////////////////////////////
	// Control
	////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			in_ready  <= 1'b1;
			row_valid <= 1'b0;
			issue_row <= '0;
			out_valid <= 1'b0;
			res_err   <= 1'b0;
		end else begin
			if (accept) begin
				// Row 0 goes out the next cycle
				in_ready  <= 1'b0;
				row_valid <= 1'b1;
				issue_row <= '0;
				res_err   <= 1'b0;
			end else if (row_valid) begin
				if (issue_row == LAST_ROW) begin
					row_valid <= 1'b0;
				end else begin
					issue_row <= issue_row + 1'b1;
				end
			end
			// Sticky over all rows of the job
			if (rsp_valid) begin
				res_err <= res_err | row_rsp.ovf;
			end
			if (last_rsp) begin
				out_valid <= 1'b1;
			end
			// Ready again only once the result has left
			if (send) begin
				out_valid <= 1'b0;
				in_ready  <= 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// Data
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (accept) begin
			job_q <= in_job;
		end
		// Rows land by their own index
		if (rsp_valid) begin
			res_w[row_rsp.row] <= row_rsp.w_row;
		end
	end

	// Current row, straight from the job copy
	always_comb begin
		row_req.row     = issue_row;
		row_req.delta_j = job_q.delta[issue_row];
		row_req.a       = job_q.a;
		row_req.w_row   = job_q.w[issue_row];
	end

	assign out_result = '{w: res_w, error: res_err};

	// Accept and deliver never overlap
	ready_valid_excl_a: assert property (@(posedge clk) disable iff (!arst_n)
		!(in_ready && out_valid))
		else $error("in_ready and out_valid both high");

	// Held result under back-pressure
	out_stable_a: assert property (@(posedge clk) disable iff (!arst_n)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_result)))
		else $error("out_result changed while stalled");

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the weight update testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f weight_update_top.f \
	--top-module tb_weight_update_top \
	-Mdir obj_dir -o sim_weight_update

# A crashed simulation also counts as a failure
./obj_dir/sim_weight_update > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Test failed" sim.log; then
	exit 1
fi
exit 0

// ==== tb/tb_weight_update_top.sv ====
`timescale 1ns/1ps
`include "nn_settings.svh"

module tb_weight_update_top;
	import nn_pkg::*;

	// Cycles any single wait may take
	localparam int TIMEOUT = 200;
	// Signed weight range
	localparam longint W_MAX = (longint'(1) <<< (`WEIGHT_CELL_WIDTH - 1)) - 1;
	localparam longint W_MIN = -W_MAX - 1;

	logic        clk;
	logic        arst_n;
	logic        cfg_we;
	cfg_wr_t     cfg;
	logic        in_valid;
	logic        in_ready;
	upd_job_t    in_job;
	logic        out_valid;
	logic        out_ready;
	upd_result_t out_result;

	// Scoreboard
	upd_result_t exp_q[$];
	upd_result_t exp_head;
	int          exp_count;
	int          errors;
	int          tests;
	int          failed;
	int          seed = 23;

	// Mirror of the configuration registers
	logic [`LR_SHIFT_WIDTH-1:0] cur_lr;
	logic                       cur_sat;

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	weight_update_top weight_update_top_inst (
		.clk        (clk       ),
		.arst_n     (arst_n    ),
		.cfg_we     (cfg_we    ),
		.cfg        (cfg       ),
		.in_valid   (in_valid  ),
		.in_ready   (in_ready  ),
		.in_job     (in_job    ),
		.out_valid  (out_valid ),
		.out_ready  (out_ready ),
		.out_result (out_result)
	);

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	// New weight = old weight minus (a_i * delta_j) scaled down by the shift
	function automatic upd_result_t expected_result(upd_job_t job, int shift, bit sat);
		upd_result_t res;
		longint      p;
		longint      d;
		res.error = 1'b0;
		for (int j = 0; j < `NEURON_NUM; j++) begin
			for (int i = 0; i < `NEURON_NUM; i++) begin
				p = longint'($signed(job.delta[j])) * longint'(job.a[i]);
				p = p >>> (`FRACTION_WIDTH + shift);
				d = longint'($signed(job.w[j][i])) - p;
				if (d > W_MAX || d < W_MIN) begin
					res.error = 1'b1;
					// Clamp when saturating, else keep the low bits
					if (sat) begin
						d = (d > W_MAX) ? W_MAX : W_MIN;
					end
				end
				res.w[j][i] = d[`WEIGHT_CELL_WIDTH-1:0];
			end
		end
		return res;
	endfunction

	function automatic void refresh_head();
		exp_count = exp_q.size();
		if (exp_count > 0) begin
			exp_head = exp_q[0];
		end else begin
			exp_head = '0;
		end
	endfunction

	function automatic upd_job_t random_job();
		upd_job_t job;
		for (int j = 0; j < `NEURON_NUM; j++) begin
			job.a[j]     = act_cell_t'($random(seed));
			job.delta[j] = delta_cell_t'($random(seed));
			for (int i = 0; i < `NEURON_NUM; i++) begin
				job.w[j][i] = weight_cell_t'($random(seed));
			end
		end
		return job;
	endfunction

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	result_known_a: assert property (@(posedge clk) disable iff (!arst_n)
		(out_valid && out_ready) |-> (exp_count > 0))
		else begin
			errors++;
			$display("Result delivered with no job outstanding");
		end

	result_w_a: assert property (@(posedge clk) disable iff (!arst_n)
		(out_valid && out_ready) |-> (out_result.w == exp_head.w))
		else begin
			errors++;
			$display("Mismatch out_result.w: got %h expected %h",
				$sampled(out_result.w), $sampled(exp_head.w));
		end

	result_err_a: assert property (@(posedge clk) disable iff (!arst_n)
		(out_valid && out_ready) |-> (out_result.error == exp_head.error))
		else begin
			errors++;
			$display("Mismatch out_result.error: got %h expected %h",
				$sampled(out_result.error), $sampled(exp_head.error));
		end

	// Held result while stalled
	stable_a: assert property (@(posedge clk) disable iff (!arst_n)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_result)))
		else begin
			errors++;
			$display("out_result changed or dropped while out_ready was low");
		end

	// Busy until the result has left
	hold_ready_a: assert property (@(posedge clk) disable iff (!arst_n)
		(!in_ready && !(out_valid && out_ready)) |=> !in_ready)
		else begin
			errors++;
			$display("in_ready rose before the result was taken");
		end

	excl_a: assert property (@(posedge clk) disable iff (!arst_n)
		out_valid |-> !in_ready)
		else begin
			errors++;
			$display("in_ready high while a result was waiting");
		end

	// Rise lands NEURON_NUM+2 edges after acceptance and shows one sample later
	latency_a: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(out_valid) == $past(in_valid && in_ready, `NEURON_NUM + 3))
		else begin
			errors++;
			$display("out_valid did not rise NEURON_NUM+2 cycles after acceptance");
		end

	reset_a: assert property (@(posedge clk)
		(!arst_n || $rose(arst_n)) |-> (in_ready && !out_valid))
		else begin
			errors++;
			$display("in_ready low or out_valid high during or just after reset");
		end

	////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic apply_reset();
		arst_n = 1'b0;
		repeat (5) next_cycle();
		arst_n = 1'b1;
	endtask

	task automatic write_cfg(input logic addr, input logic [7:0] data);
		cfg_we   = 1'b1;
		cfg.addr = addr;
		cfg.data = data;
		next_cycle();
		cfg_we = 1'b0;
		if (addr == CFG_ADDR_LR_SHIFT) begin
			cur_lr = data[`LR_SHIFT_WIDTH-1:0];
		end else begin
			cur_sat = data[0];
		end
	endtask

	// One job in, one result out after stall cycles of back-pressure
	task automatic run_job(input upd_job_t job, input int stall);
		int wait_cnt;
		wait_cnt = 0;
		while (!in_ready && wait_cnt < TIMEOUT) begin
			next_cycle();
			wait_cnt++;
		end
		if (!in_ready) begin
			errors++;
			$display("Timed out waiting for in_ready");
			return;
		end
		in_valid = 1'b1;
		in_job   = job;
		exp_q.push_back(expected_result(job, int'(cur_lr), cur_sat));
		refresh_head();
		next_cycle();
		in_valid = 1'b0;
		wait_cnt = 0;
		while (!out_valid && wait_cnt < TIMEOUT) begin
			next_cycle();
			wait_cnt++;
		end
		if (!out_valid) begin
			errors++;
			$display("Timed out waiting for out_valid, result lost");
			return;
		end
		repeat (stall) next_cycle();
		out_ready = 1'b1;
		next_cycle();
		exp_q.delete(0);
		refresh_head();
		// Still ready one more edge so a repeated result would transfer
		next_cycle();
		out_ready = 1'b0;
	endtask

	task automatic end_test(input string name, input int errors_before);
		tests++;
		if (errors == errors_before) begin
			$display("%s: ok", name);
		end else begin
			failed++;
			$display("%s: FAILED with %0d errors", name, errors - errors_before);
		end
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		upd_job_t job;
		int       errs_at;
		int       stall;
		cfg_we    = 1'b0;
		cfg       = '0;
		in_valid  = 1'b0;
		in_job    = '0;
		out_ready = 1'b0;
		arst_n    = 1'b1;
		errors    = 0;
		tests     = 0;
		failed    = 0;
		cur_lr    = '0;
		cur_sat   = 1'b1;
		refresh_head();
		#1;
		apply_reset();

		// Small known vector
		errs_at = errors;
		for (int j = 0; j < `NEURON_NUM; j++) begin
			job.a[j]     = act_cell_t'(10 * (j + 1));
			job.delta[j] = delta_cell_t'(j + 1);
			for (int i = 0; i < `NEURON_NUM; i++) begin
				job.w[j][i] = weight_cell_t'(j * `NEURON_NUM + i);
			end
		end
		run_job(job, 0);
		end_test("known vector", errs_at);

		errs_at = errors;
		write_cfg(CFG_ADDR_LR_SHIFT, 8'd2);
		repeat (20) run_job(random_job(), 0);
		write_cfg(CFG_ADDR_LR_SHIFT, 8'd5);
		repeat (20) run_job(random_job(), 0);
		end_test("learning rate", errs_at);

		// Large positive products pull weights far below the minimum
		errs_at = errors;
		write_cfg(CFG_ADDR_LR_SHIFT, 8'd0);
		for (int j = 0; j < `NEURON_NUM; j++) begin
			job.a[j]     = act_cell_t'(511);
			job.delta[j] = delta_cell_t'(2047);
			for (int i = 0; i < `NEURON_NUM; i++) begin
				job.w[j][i] = weight_cell_t'(W_MIN + 100 + 7 * i);
			end
		end
		run_job(job, 0);
		end_test("saturation", errs_at);

		errs_at = errors;
		write_cfg(CFG_ADDR_SAT_EN, 8'd0);
		run_job(job, 0);
		write_cfg(CFG_ADDR_SAT_EN, 8'd1);
		end_test("wrap", errs_at);

		errs_at = errors;
		write_cfg(CFG_ADDR_LR_SHIFT, 8'd3);
		for (int n = 0; n < 10; n++) begin
			stall = {$random(seed)} % 8;
			run_job(random_job(), stall);
		end
		end_test("back-pressure", errs_at);

		// Reset with rows in flight and then one clean job
		errs_at = errors;
		in_valid = 1'b1;
		in_job   = random_job();
		next_cycle();
		in_valid = 1'b0;
		repeat (3) next_cycle();
		apply_reset();
		cur_lr  = '0;
		cur_sat = 1'b1;
		run_job(random_job(), 1);
		end_test("reset", errs_at);

		next_cycle();
		$display("Summary: %0d tests, %0d failed, %0d errors", tests, failed, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== weight_update_top.f ====
+incdir+hw
hw/nn_pkg.sv
hw/update_cfg_regs.sv
hw/weight_row_update.sv
hw/weight_updater.sv
hw/weight_update_top.sv
tb/tb_weight_update_top.sv
